// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_icmp_echo \
		-f icmp_echo.f -Mdir obj_dir
	./obj_dir/Vtb_icmp_echo | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: include/icmp_tb_ref.svh
`ifndef ICMP_TB_REF_SVH
`define ICMP_TB_REF_SVH

// ones' complement checksum of a message with an odd tail padded by zero
function automatic icmp_pkg::word_t ref_checksum(input icmp_pkg::byte_t msg[$]);
    icmp_pkg::sum_t  acc;
    icmp_pkg::word_t w;
    acc = '0;
    for (int i = 0; i < msg.size(); i += 2)
    begin
        w   = {msg[i], (i + 1 < msg.size()) ? msg[i + 1] : 8'h00};
        acc = acc + {16'h0000, w};
    end
    while (acc[31:16] != '0)
        acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
    return ~acc[15:0];
endfunction

// expected echo reply for a request
function automatic void ref_reply(input  icmp_pkg::byte_t req[$],
                                  output icmp_pkg::byte_t rsp[$]);
    icmp_pkg::word_t sum;
    rsp    = req;
    rsp[0] = icmp_pkg::ECHO_REPLY;
    rsp[2] = 8'h00;
    rsp[3] = 8'h00;
    sum    = ref_checksum(rsp);
    rsp[2] = sum[15:8];
    rsp[3] = sum[7:0];
endfunction

`endif

// File: dv/tb_icmp_echo.sv
`timescale 1ns/1ps

module tb_icmp_echo;

    localparam int TX_WAIT    = 200;    // data request timeout of the DUT
    localparam int REQ_WAIT   = 50;     // cycles allowed for icmp_tx_req
    localparam int REPLY_WAIT = 1000;
    localparam int MAX_REPLY  = 400;

    logic            clk;
    logic            rstn;
    logic            icmp_rx_req;
    icmp_pkg::byte_t icmp_rx_data;
    logic            icmp_rev_error;
    icmp_pkg::len_t  upper_layer_data_length;
    logic            ip_tx_ack;
    logic            icmp_data_req;
    logic            mac_send_end;
    logic            icmp_tx_req;
    logic            icmp_tx_ready;
    icmp_pkg::byte_t icmp_tx_data;
    logic            icmp_tx_end;

    integer          seed;
    int              replies_checked;
    icmp_pkg::byte_t exp_bytes[$];      // expected replies back to back
    int              exp_lens[$];
    string           exp_names[$];
    icmp_pkg::byte_t got_bytes[$];      // last reply seen by the monitor
    event            reply_done;

    `include "icmp_tb_ref.svh"

    icmp_echo #(.TX_WAIT_LIMIT(TX_WAIT)) dut0 (
        .clk                     (clk),
        .rstn                    (rstn),
        .icmp_rx_req             (icmp_rx_req),
        .icmp_rx_data            (icmp_rx_data),
        .icmp_rev_error          (icmp_rev_error),
        .upper_layer_data_length (upper_layer_data_length),
        .ip_tx_ack               (ip_tx_ack),
        .icmp_data_req           (icmp_data_req),
        .mac_send_end            (mac_send_end),
        .icmp_tx_req             (icmp_tx_req),
        .icmp_tx_ready           (icmp_tx_ready),
        .icmp_tx_data            (icmp_tx_data),
        .icmp_tx_end             (icmp_tx_end)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("** Error %s: expected 'h%0h, actual 'h%0h", name, expected, actual);
            stop_run();
        end
    endtask

    // echo message with random code, id, seq and payload and a valid checksum
    task automatic make_request(input int len, input icmp_pkg::byte_t msg_type,
                                output icmp_pkg::byte_t msg[$]);
        icmp_pkg::word_t sum;
        msg = {};
        msg.push_back(msg_type);
        msg.push_back(8'($random(seed)));
        msg.push_back(8'h00);
        msg.push_back(8'h00);
        for (int i = 4; i < len; i++)
            msg.push_back(8'($random(seed)));
        sum    = ref_checksum(msg);
        msg[2] = sum[15:8];
        msg[3] = sum[7:0];
    endtask

    task automatic send_request(input icmp_pkg::byte_t msg[$], input int err_at);
        @(posedge clk);
        upper_layer_data_length <= 16'(msg.size());
        icmp_rx_req             <= 1'b1;
        foreach (msg[i])
        begin
            @(posedge clk);
            icmp_rx_req    <= 1'b0;
            icmp_rx_data   <= msg[i];
            icmp_rev_error <= (i == err_at);
        end
        @(posedge clk);     // edge that takes the last byte
        icmp_rx_data   <= '0;
        icmp_rev_error <= 1'b0;
    endtask

    // cycles from the last byte to icmp_tx_req or -1 if none
    task automatic wait_tx_req(output int cycles);
        int n;
        n      = 0;
        cycles = -1;
        while (n < REQ_WAIT && cycles < 0)
        begin
            @(posedge clk);
            n++;
            @(negedge clk);
            if (icmp_tx_req)
                cycles = n;
        end
    endtask

    task automatic grant_request(input string name, input int ack_delay);
        repeat (ack_delay)
        begin
            @(negedge clk);
            check_value({name, " tx_req held"}, 1, icmp_tx_req);
        end
        @(posedge clk);
        ip_tx_ack <= 1'b1;
        @(posedge clk);
        ip_tx_ack <= 1'b0;
        @(negedge clk);
        check_value({name, " tx_req after ack"}, 0, icmp_tx_req);
        check_value({name, " tx_ready after ack"}, 1, icmp_tx_ready);
    endtask

    task automatic release_reply(input string name, input int dreq_delay);
        int start;
        int n;
        start = replies_checked;
        n     = 0;
        repeat (dreq_delay)
        begin
            @(negedge clk);
            check_value({name, " tx_ready held"}, 1, icmp_tx_ready);
        end
        @(posedge clk);
        icmp_data_req <= 1'b1;
        @(posedge clk);
        icmp_data_req <= 1'b0;
        while (replies_checked == start)
        begin
            @(negedge clk);
            n++;
            if (n > REPLY_WAIT)
            begin
                $display("timeout: %s got no complete reply in %0d cycles", name, REPLY_WAIT);
                stop_run();
            end
        end
        @(posedge clk);
        mac_send_end <= 1'b1;
        @(posedge clk);
        mac_send_end <= 1'b0;
    endtask

    task automatic echo_exchange(input string name, input icmp_pkg::byte_t msg[$],
                                 input int ack_delay, input int dreq_delay);
        icmp_pkg::byte_t rsp[$];
        int              cycles;
        ref_reply(msg, rsp);
        foreach (rsp[i])
            exp_bytes.push_back(rsp[i]);
        exp_lens.push_back(rsp.size());
        exp_names.push_back(name);
        send_request(msg, -1);
        wait_tx_req(cycles);
        if (cycles < 0)
        begin
            $display("timeout: %s raised no icmp_tx_req in %0d cycles", name, REQ_WAIT);
            stop_run();
        end
        check_value({name, " tx_req latency"}, 5, cycles);
        grant_request(name, ack_delay);
        release_reply(name, dreq_delay);
    endtask

    task automatic expect_no_reply(input string name, input icmp_pkg::byte_t msg[$],
                                   input int err_at);
        int cycles;
        send_request(msg, err_at);
        wait_tx_req(cycles);
        if (cycles >= 0)
        begin
            $display("%s was not dropped, icmp_tx_req came after %0d cycles", name, cycles);
            stop_run();
        end
    endtask

    // ack the request but never ask for data
    task automatic let_data_req_lapse(input string name, input icmp_pkg::byte_t msg[$]);
        int cycles;
        int n;
        send_request(msg, -1);
        wait_tx_req(cycles);
        if (cycles < 0)
        begin
            $display("timeout: %s raised no icmp_tx_req in %0d cycles", name, REQ_WAIT);
            stop_run();
        end
        grant_request(name, 0);
        n = 1;
        while (icmp_tx_ready)
        begin
            @(negedge clk);
            check_value({name, " tx_data idle"}, 0, icmp_tx_data);
            check_value({name, " tx_end idle"}, 0, icmp_tx_end);
            if (icmp_tx_ready)
                n++;
            if (n > 2 * TX_WAIT)
            begin
                $display("timeout: %s kept icmp_tx_ready high for %0d cycles", name, n);
                stop_run();
            end
        end
        check_value({name, " tx_ready cycles"}, TX_WAIT, n);
        check_value({name, " tx_req after timeout"}, 0, icmp_tx_req);
    endtask

    ////////////////////////////////////////////////////////////
    // reply monitor and compare
    ////////////////////////////////////////////////////////////

    initial
    begin : reply_monitor
        icmp_pkg::byte_t bytes[$];
        forever
        begin
            @(negedge clk);
            if (icmp_data_req && icmp_tx_ready)
            begin
                bytes = {};
                repeat (3) @(posedge clk);  // sampling edge of the data request and two more
                do
                begin
                    @(negedge clk);
                    bytes.push_back(icmp_tx_data);
                    if (bytes.size() > MAX_REPLY)
                    begin
                        $display("reply ran past %0d bytes without icmp_tx_end", MAX_REPLY);
                        stop_run();
                    end
                end
                while (!icmp_tx_end);
                got_bytes = bytes;
                -> reply_done;
            end
        end
    end

    always @(reply_done)
    begin : compare_replies
        string name;
        int    len;
        if (exp_lens.size() == 0)
        begin
            $display("reply seen on icmp_tx_data with no request outstanding");
            stop_run();
        end
        name = exp_names.pop_front();
        len  = exp_lens.pop_front();
        check_value({name, " reply length"}, len, got_bytes.size());
        for (int i = 0; i < len; i++)
            check_value($sformatf("%s byte %0d", name, i), exp_bytes.pop_front(), got_bytes[i]);
        replies_checked++;
    end

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    initial
    begin : run_tests
        icmp_pkg::byte_t msg[$];
        int              len;
        clk                     = 1'b0;
        rstn                    = 1'b0;
        icmp_rx_req             = 1'b0;
        icmp_rx_data            = '0;
        icmp_rev_error          = 1'b0;
        upper_layer_data_length = '0;
        ip_tx_ack               = 1'b0;
        icmp_data_req           = 1'b0;
        mac_send_end            = 1'b0;
        seed                    = 1;
        replies_checked         = 0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_value("reset tx_req", 0, icmp_tx_req);
        check_value("reset tx_ready", 0, icmp_tx_ready);
        check_value("reset tx_end", 0, icmp_tx_end);
        check_value("reset tx_data", 0, icmp_tx_data);

        make_request(40, icmp_pkg::ECHO_REQUEST, msg);
        echo_exchange("even length", msg, 0, 0);
        make_request(8, icmp_pkg::ECHO_REQUEST, msg);
        echo_exchange("header only", msg, 1, 1);
        make_request(21, icmp_pkg::ECHO_REQUEST, msg);
        echo_exchange("odd length", msg, 2, 3);

        // drops followed by a good request
        make_request(24, icmp_pkg::ECHO_REQUEST, msg);
        msg[3] = msg[3] ^ 8'h5a;
        expect_no_reply("bad checksum", msg, -1);
        make_request(24, 8'h0d, msg);
        expect_no_reply("wrong type", msg, -1);
        make_request(30, icmp_pkg::ECHO_REQUEST, msg);
        echo_exchange("after drops", msg, 0, 0);

        make_request(32, icmp_pkg::ECHO_REQUEST, msg);
        expect_no_reply("receive error", msg, 12);
        make_request(17, icmp_pkg::ECHO_REQUEST, msg);
        echo_exchange("after receive error", msg, 0, 0);

        for (int i = 0; i < 6; i++)
        begin
            len = 8 + int'($unsigned($random(seed)) % 257);     // up to a full RAM
            make_request(len, icmp_pkg::ECHO_REQUEST, msg);
            echo_exchange($sformatf("back-pressure %0d", i), msg,
                          int'($unsigned($random(seed)) % 20),
                          int'($unsigned($random(seed)) % 40));
        end

        make_request(20, icmp_pkg::ECHO_REQUEST, msg);
        let_data_req_lapse("data request timeout", msg);
        make_request(25, icmp_pkg::ECHO_REQUEST, msg);
        echo_exchange("after timeout", msg, 0, 0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: icmp_echo.f
+incdir+include
verilog/icmp_pkg.sv
verilog/icmp_echo_if.sv
verilog/icmp_rx_parser.sv
verilog/icmp_checksum.sv
verilog/icmp_payload_ram.sv
verilog/icmp_reply_tx.sv
verilog/icmp_echo.sv
dv/tb_icmp_echo.sv

// File: verilog/icmp_checksum.sv
`timescale 1ns/1ps

module icmp_checksum (
    input  logic   clk,
    input  logic   rstn,
    icmp_sum_if.acc feed
);

    icmp_pkg::sum_t  acc;
    icmp_pkg::sum_t  fold1;
    icmp_pkg::word_t fold2;
    icmp_pkg::byte_t hi_byte;     // upper half of the pending word
    logic            have_hi;
    logic            last_seen;
    logic            fold1_vld;
    logic            fold2_vld;

    // big-endian pairs into the accumulator
    always_ff @(posedge clk)
    begin
        if (!rstn || feed.clear)
        begin
            acc     <= '0;
            have_hi <= 1'b0;
        end
        else if (feed.data_en)
        begin
            if (have_hi)
            begin
                acc     <= acc + {16'h0000, hi_byte, feed.data};
                have_hi <= 1'b0;
            end
            else if (feed.last)
                acc <= acc + {16'h0000, feed.data, 8'h00};    // odd tail, zero pad
            else
                have_hi <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (feed.data_en && !have_hi)
            hi_byte <= feed.data;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn || feed.clear)
        begin
            last_seen <= 1'b0;
            fold1_vld <= 1'b0;
            fold2_vld <= 1'b0;
            feed.done <= 1'b0;
        end
        else
        begin
            last_seen <= feed.data_en && feed.last;
            fold1_vld <= last_seen;
            fold2_vld <= fold1_vld;
            feed.done <= fold2_vld;
        end
    end

    // two folds are enough for a 32 bit sum
    always_ff @(posedge clk)
    begin
        fold1 <= {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
        fold2 <= fold1[15:0] + fold1[31:16];
        if (fold2_vld)
            feed.sum <= ~fold2;
    end

    // feeder leaves a gap between clear and the first byte
    assert property (@(posedge clk) disable iff (!rstn) feed.clear |=> !feed.data_en);

endmodule

// File: verilog/icmp_echo.sv
`timescale 1ns/1ps

module icmp_echo #(
    parameter int PAYLOAD_DEPTH = 256,
    parameter int TX_WAIT_LIMIT = 65535
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            icmp_rx_req,
    input  icmp_pkg::byte_t icmp_rx_data,
    input  logic            icmp_rev_error,
    input  icmp_pkg::len_t  upper_layer_data_length,
    input  logic            ip_tx_ack,
    input  logic            icmp_data_req,
    input  logic            mac_send_end,
    output logic            icmp_tx_req,
    output logic            icmp_tx_ready,
    output icmp_pkg::byte_t icmp_tx_data,
    output logic            icmp_tx_end
);

    localparam int AW = $clog2(PAYLOAD_DEPTH);

    icmp_hdr_if hdr_if ();
    icmp_sum_if verify_if ();
    icmp_sum_if reply_if ();

    logic            ram_wr_en;
    logic [AW-1:0]   ram_wr_addr;
    logic [AW-1:0]   ram_rd_addr;
    icmp_pkg::byte_t ram_wr_data;
    icmp_pkg::byte_t ram_rd_data;

    icmp_rx_parser #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH)) u_rx_parser (
        .clk        (clk),
        .rstn       (rstn),
        .rx_req     (icmp_rx_req),
        .rx_data    (icmp_rx_data),
        .rev_error  (icmp_rev_error),
        .rx_length  (upper_layer_data_length),
        .verify_sum (verify_if),
        .reply_sum  (reply_if),
        .hdr        (hdr_if),
        .wr_en      (ram_wr_en),
        .wr_addr    (ram_wr_addr),
        .wr_data    (ram_wr_data)
    );

    // received bytes as they are
    icmp_checksum u_verify_sum (.clk(clk), .rstn(rstn), .feed(verify_if));
    // reply image, type and checksum zeroed
    icmp_checksum u_reply_sum (.clk(clk), .rstn(rstn), .feed(reply_if));

    icmp_payload_ram #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH)) u_payload_ram (
        .clk     (clk),
        .wr_en   (ram_wr_en),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

    icmp_reply_tx #(
        .PAYLOAD_DEPTH (PAYLOAD_DEPTH),
        .TX_WAIT_LIMIT (TX_WAIT_LIMIT)
    ) u_reply_tx (
        .clk          (clk),
        .rstn         (rstn),
        .hdr          (hdr_if),
        .ip_tx_ack    (ip_tx_ack),
        .data_req     (icmp_data_req),
        .mac_send_end (mac_send_end),
        .tx_req       (icmp_tx_req),
        .tx_ready     (icmp_tx_ready),
        .tx_data      (icmp_tx_data),
        .tx_end       (icmp_tx_end),
        .rd_addr      (ram_rd_addr),
        .rd_data      (ram_rd_data)
    );

endmodule

// File: verilog/icmp_echo_if.sv
`timescale 1ns/1ps

// accepted message, parser to reply transmitter
interface icmp_hdr_if;
    logic            valid;
    logic            ready;      // transmitter idle
    icmp_pkg::byte_t code;
    icmp_pkg::word_t id;
    icmp_pkg::word_t seq;
    icmp_pkg::len_t  length;
    icmp_pkg::word_t reply_sum;

    modport parser (output valid, code, id, seq, length, reply_sum, input ready);
    modport tx     (input valid, code, id, seq, length, reply_sum, output ready);
endinterface

// byte feed into a checksum unit
interface icmp_sum_if;
    logic            clear;
    icmp_pkg::byte_t data;
    logic            data_en;
    logic            last;
    icmp_pkg::word_t sum;        // complemented result
    logic            done;

    modport feeder (output clear, data, data_en, last, input sum, done);
    modport acc    (input clear, data, data_en, last, output sum, done);
endinterface

// File: verilog/icmp_payload_ram.sv
`timescale 1ns/1ps

module icmp_payload_ram #(
    parameter int PAYLOAD_DEPTH = 256
) (
    input  logic                             clk,
    input  logic                             wr_en,
    input  logic [$clog2(PAYLOAD_DEPTH)-1:0] wr_addr,
    input  icmp_pkg::byte_t                  wr_data,
    input  logic [$clog2(PAYLOAD_DEPTH)-1:0] rd_addr,
    output icmp_pkg::byte_t                  rd_data
);

    icmp_pkg::byte_t mem [PAYLOAD_DEPTH];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // one cycle read latency
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/icmp_pkg.sv
package icmp_pkg;

    ////////////////////////////////////////////////////////////
    // data widths
    ////////////////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;    // one message byte
    typedef logic [15:0] word_t;    // id, seq, checksum or a byte pair
    typedef logic [15:0] len_t;     // message length in bytes
    typedef logic [31:0] sum_t;     // checksum accumulator before folding

    ////////////////////////////////////////////////////////////
    // ICMP constants
    ////////////////////////////////////////////////////////////

    localparam byte_t ECHO_REQUEST = 8'h08;
    localparam byte_t ECHO_REPLY   = 8'h00;
    localparam len_t  HDR_BYTES    = 16'd8;    // type, code, checksum, id, seq

    // receive side
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_RECEIVE,
        RX_VERIFY,      // waiting for the checksum pipeline
        RX_DROP,
        RX_HANDOFF
    } rx_state_t;

    // reply side
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_REQUEST,
        TX_WAIT_ACK,
        TX_WAIT_DATA_REQ,
        TX_SEND,
        TX_WAIT_MAC_END
    } tx_state_t;

endpackage

// File: verilog/icmp_reply_tx.sv
`timescale 1ns/1ps

module icmp_reply_tx #(
    parameter int PAYLOAD_DEPTH = 256,
    parameter int TX_WAIT_LIMIT = 65535
) (
    input  logic                             clk,
    input  logic                             rstn,
    icmp_hdr_if.tx                           hdr,
    input  logic                             ip_tx_ack,
    input  logic                             data_req,
    input  logic                             mac_send_end,
    output logic                             tx_req,
    output logic                             tx_ready,
    output icmp_pkg::byte_t                  tx_data,
    output logic                             tx_end,
    output logic [$clog2(PAYLOAD_DEPTH)-1:0] rd_addr,
    input  icmp_pkg::byte_t                  rd_data
);

    localparam int AW     = $clog2(PAYLOAD_DEPTH);
    localparam int WAIT_W = $clog2(TX_WAIT_LIMIT + 1);
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(TX_WAIT_LIMIT - 1);

    icmp_pkg::tx_state_t state;
    icmp_pkg::tx_state_t state_n;
    icmp_pkg::len_t      cnt;        // output lags the byte sequencer by one
    icmp_pkg::len_t      rd_offset;
    logic [WAIT_W-1:0]   wait_cnt;
    icmp_pkg::byte_t     code_q;
    icmp_pkg::word_t     id_q;
    icmp_pkg::word_t     seq_q;
    icmp_pkg::word_t     sum_q;
    icmp_pkg::len_t      len_q;

    always_comb
    begin
        state_n = state;
        case (state)
            icmp_pkg::TX_IDLE:
                if (hdr.valid)
                    state_n = icmp_pkg::TX_REQUEST;
            icmp_pkg::TX_REQUEST:
                state_n = ip_tx_ack ? icmp_pkg::TX_WAIT_DATA_REQ : icmp_pkg::TX_WAIT_ACK;
            icmp_pkg::TX_WAIT_ACK:
                if (ip_tx_ack)
                    state_n = icmp_pkg::TX_WAIT_DATA_REQ;
            icmp_pkg::TX_WAIT_DATA_REQ:
                if (data_req)
                    state_n = icmp_pkg::TX_SEND;
                else if (wait_cnt == WAIT_LAST)   // reply is lost at the wait limit
                    state_n = icmp_pkg::TX_IDLE;
            icmp_pkg::TX_SEND:
                if (cnt == len_q)
                    state_n = icmp_pkg::TX_WAIT_MAC_END;
            icmp_pkg::TX_WAIT_MAC_END:
                if (mac_send_end)
                    state_n = icmp_pkg::TX_IDLE;
            default:
                state_n = icmp_pkg::TX_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            state <= icmp_pkg::TX_IDLE;
        else
            state <= state_n;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn || state != icmp_pkg::TX_WAIT_DATA_REQ)
            wait_cnt <= '0;
        else
            wait_cnt <= wait_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn || state != icmp_pkg::TX_SEND)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // take the message over from the parser
    always_ff @(posedge clk)
    begin
        if (state == icmp_pkg::TX_IDLE && hdr.valid)
        begin
            code_q <= hdr.code;
            id_q   <= hdr.id;
            seq_q  <= hdr.seq;
            sum_q  <= hdr.reply_sum;
            len_q  <= hdr.length;
        end
    end

    assign hdr.ready = (state == icmp_pkg::TX_IDLE);
    assign tx_req    = (state == icmp_pkg::TX_REQUEST) || (state == icmp_pkg::TX_WAIT_ACK);
    assign tx_ready  = (state == icmp_pkg::TX_WAIT_DATA_REQ);

    ////////////////////////////////////////////////////////////
    // reply byte stream
    ////////////////////////////////////////////////////////////

    // read one ahead to cover the RAM latency
    assign rd_offset = cnt - icmp_pkg::HDR_BYTES;
    assign rd_addr   = rd_offset[AW-1:0];

    always_ff @(posedge clk)
    begin
        if (!rstn || state != icmp_pkg::TX_SEND)
        begin
            tx_data <= '0;
            tx_end  <= 1'b0;
        end
        else
        begin
            tx_end <= (cnt == len_q);
            case (cnt)
                16'd0:   tx_data <= '0;
                16'd1:   tx_data <= icmp_pkg::ECHO_REPLY;
                16'd2:   tx_data <= code_q;
                16'd3:   tx_data <= sum_q[15:8];
                16'd4:   tx_data <= sum_q[7:0];
                16'd5:   tx_data <= id_q[15:8];
                16'd6:   tx_data <= id_q[7:0];
                16'd7:   tx_data <= seq_q[15:8];
                16'd8:   tx_data <= seq_q[7:0];
                default: tx_data <= rd_data;
            endcase
        end
    end

    // handed over lengths cover the header and fit the RAM
    assert property (@(posedge clk) disable iff (!rstn)
        hdr.valid |-> (hdr.length >= icmp_pkg::HDR_BYTES) &&
                      (hdr.length <= icmp_pkg::len_t'(PAYLOAD_DEPTH) + icmp_pkg::HDR_BYTES));

endmodule

// File: verilog/icmp_rx_parser.sv
`timescale 1ns/1ps

module icmp_rx_parser #(
    parameter int PAYLOAD_DEPTH = 256
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             rx_req,
    input  icmp_pkg::byte_t                  rx_data,
    input  logic                             rev_error,
    input  icmp_pkg::len_t                   rx_length,
    icmp_sum_if.feeder                       verify_sum,
    icmp_sum_if.feeder                       reply_sum,
    icmp_hdr_if.parser                       hdr,
    output logic                             wr_en,
    output logic [$clog2(PAYLOAD_DEPTH)-1:0] wr_addr,
    output icmp_pkg::byte_t                  wr_data
);

    localparam int AW = $clog2(PAYLOAD_DEPTH);
    localparam icmp_pkg::len_t MAX_LEN = icmp_pkg::len_t'(PAYLOAD_DEPTH) + icmp_pkg::HDR_BYTES;

    icmp_pkg::rx_state_t state;
    icmp_pkg::rx_state_t state_n;
    icmp_pkg::len_t      len_q;
    icmp_pkg::len_t      cnt;        // index of the byte on rx_data
    icmp_pkg::len_t      wr_offset;
    icmp_pkg::byte_t     code_q;
    icmp_pkg::word_t     id_q;
    icmp_pkg::word_t     seq_q;
    logic                feed_en;
    logic                len_bad;
    logic                last_byte;
    logic                sum_clear;

    assign feed_en   = (state == icmp_pkg::RX_RECEIVE);
    assign len_bad   = (len_q < icmp_pkg::HDR_BYTES) || (len_q > MAX_LEN);
    assign last_byte = (cnt == len_q - 1'b1);
    assign sum_clear = (state == icmp_pkg::RX_DROP) ||
                       (state == icmp_pkg::RX_HANDOFF && hdr.ready);

    always_comb
    begin
        state_n = state;
        case (state)
            icmp_pkg::RX_IDLE:
                if (rx_req)
                    state_n = icmp_pkg::RX_RECEIVE;
            icmp_pkg::RX_RECEIVE:
                if (rev_error || len_bad || (cnt == '0 && rx_data != icmp_pkg::ECHO_REQUEST))
                    state_n = icmp_pkg::RX_DROP;
                else if (last_byte)
                    state_n = icmp_pkg::RX_VERIFY;
            icmp_pkg::RX_VERIFY:
                if (rev_error)
                    state_n = icmp_pkg::RX_DROP;
                else if (verify_sum.done)   // good message sums to zero
                    state_n = (verify_sum.sum == '0) ? icmp_pkg::RX_HANDOFF : icmp_pkg::RX_DROP;
            icmp_pkg::RX_DROP:
                state_n = icmp_pkg::RX_IDLE;
            icmp_pkg::RX_HANDOFF:
                if (hdr.ready)
                    state_n = icmp_pkg::RX_IDLE;
            default:
                state_n = icmp_pkg::RX_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            state <= icmp_pkg::RX_IDLE;
        else
            state <= state_n;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn || !feed_en)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // length is sampled with the request pulse
    always_ff @(posedge clk)
    begin
        if (state == icmp_pkg::RX_IDLE && rx_req)
            len_q <= rx_length;
    end

    ////////////////////////////////////////////////////////////
    // header capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (feed_en)
        begin
            case (cnt)
                16'd1:   code_q       <= rx_data;
                16'd4:   id_q[15:8]   <= rx_data;
                16'd5:   id_q[7:0]    <= rx_data;
                16'd6:   seq_q[15:8]  <= rx_data;
                16'd7:   seq_q[7:0]   <= rx_data;
                default: ;
            endcase
        end
    end

    assign verify_sum.clear   = sum_clear;
    assign verify_sum.data    = rx_data;
    assign verify_sum.data_en = feed_en;
    assign verify_sum.last    = last_byte;

    // reply sum sees type and checksum as zero
    assign reply_sum.clear   = sum_clear;
    assign reply_sum.data    = (cnt == 16'd0 || cnt == 16'd2 || cnt == 16'd3) ? 8'h00 : rx_data;
    assign reply_sum.data_en = feed_en;
    assign reply_sum.last    = last_byte;

    assign hdr.valid     = (state == icmp_pkg::RX_HANDOFF);
    assign hdr.code      = code_q;
    assign hdr.id        = id_q;
    assign hdr.seq       = seq_q;
    assign hdr.length    = len_q;
    assign hdr.reply_sum = reply_sum.sum;   // held until the next done

    // payload starts after the header
    assign wr_offset = cnt - icmp_pkg::HDR_BYTES;
    assign wr_en     = feed_en && (cnt >= icmp_pkg::HDR_BYTES);
    assign wr_addr   = wr_offset[AW-1:0];
    assign wr_data   = rx_data;

    // the length check upstream keeps payload writes inside the RAM
    assert property (@(posedge clk) disable iff (!rstn)
        wr_en |-> wr_offset < icmp_pkg::len_t'(PAYLOAD_DEPTH));

endmodule
